// ==== hw/uart_line_pkg.sv ====
// UART line constants
// serial character format and bit timing shared by the
// transmitter and the receiver

`default_nettype none

package uart_line_pkg;

	// clock cycles per serial bit
	localparam int CLKS_PER_BIT = 16;

	// data bits per character, 8N1 format
	localparam int DATA_BITS = 8;

	// wide enough to count a full bit period
	typedef logic [$clog2(CLKS_PER_BIT + 1) - 1:0] half_bit_cnt_t;

endpackage

`default_nettype wire

// ==== hw/frame_pkg.sv ====
// Frame constants
// marker byte, payload size and payload types for the
// frame sender, the frame receiver and the top level

`default_nettype none

package frame_pkg;

	// largest payload in bytes
	localparam int MAX_PAYLOAD = 16;

	// '&' opens and closes a frame, sent twice each time
	localparam logic [7:0] MARKER_CHAR = 8'h26;

	// byte 0 goes out first
	typedef logic [MAX_PAYLOAD - 1:0][7:0] payload_t;

	// 1 to 16, zero only after reset
	typedef logic [4:0] payload_len_t;

endpackage

`default_nettype wire

// ==== hw/uart_byte_if.sv ====
// Byte request interface
// one byte strobe from the frame sender and its completion
// from the serial transmitter

`default_nettype none
`timescale 1ns/1ps

interface uart_byte_if;

	logic [7:0] byte_data;
	logic       byte_stb;
	logic       byte_done;
	logic       line_busy;

	// strobe only while line_busy is low
	modport sender (output byte_data, output byte_stb, input byte_done, input line_busy);

	modport serializer (input byte_data, input byte_stb, output byte_done, output line_busy);

endinterface

`default_nettype wire

// ==== hw/uart_tx.sv ====
// UART transmitter
// sends one 8N1 character per byte strobe, LSB first,
// and pulses byte_done once the stop bit is over

`default_nettype none
`timescale 1ns/1ps

module uart_tx (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	uart_byte_if.serializer byte_if,
	output logic            uart_tx_port
);

	import uart_line_pkg::*;

	typedef logic [$clog2(DATA_BITS) - 1:0] bit_idx_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t            state;
	half_bit_cnt_t        clk_cnt;
	bit_idx_t             bit_idx;
	logic [DATA_BITS-1:0] shift_reg;
	logic                 bit_end;

	assign bit_end = (clk_cnt == half_bit_cnt_t'(CLKS_PER_BIT - 1));
	assign byte_if.line_busy = (state != TX_IDLE);

	// character in flight, shifted right after each data bit
	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && byte_if.byte_stb) begin
			shift_reg <= byte_if.byte_data;
		end else if (state == TX_DATA && bit_end) begin
			shift_reg <= shift_reg >> 1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state             <= TX_IDLE;
			clk_cnt           <= '0;
			bit_idx           <= '0;
			uart_tx_port      <= 1'b1;
			byte_if.byte_done <= 1'b0;
		end else begin
			byte_if.byte_done <= 1'b0;
			clk_cnt           <= (state == TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					if (byte_if.byte_stb) begin
						state        <= TX_START;
						uart_tx_port <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state        <= TX_DATA;
						bit_idx      <= '0;
						uart_tx_port <= shift_reg[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
							state        <= TX_STOP;
							uart_tx_port <= 1'b1;
						end else begin
							bit_idx      <= bit_idx + 1'b1;
							// shift_reg moves on at this same edge
							uart_tx_port <= shift_reg[1];
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state             <= TX_IDLE;
						byte_if.byte_done <= 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
// UART receiver
// 8N1 input with a two flop synchronizer, start bit recheck at
// half a bit, mid-bit sampling and a stop bit check

`default_nettype none
`timescale 1ns/1ps

module uart_rx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx_port,
	output logic [7:0] rx_byte,
	output logic       rx_stb,
	output logic       rx_stop_err
);

	import uart_line_pkg::*;

	typedef logic [$clog2(DATA_BITS) - 1:0] bit_idx_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t            state;
	logic                 rx_meta;
	logic                 rx_line;
	logic                 rx_line_d;
	half_bit_cnt_t        clk_cnt;
	bit_idx_t             bit_idx;
	logic [DATA_BITS-1:0] shift_reg;
	logic                 half_end;
	logic                 bit_end;
	logic                 start_edge;

	assign half_end   = (clk_cnt == half_bit_cnt_t'(CLKS_PER_BIT / 2 - 1));
	assign bit_end    = (clk_cnt == half_bit_cnt_t'(CLKS_PER_BIT - 1));
	assign start_edge = rx_line_d & ~rx_line;

	// line idles high, so the flops come out of reset high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta   <= 1'b1;
			rx_line   <= 1'b1;
			rx_line_d <= 1'b1;
		end else begin
			rx_meta   <= uart_rx_port;
			rx_line   <= rx_meta;
			rx_line_d <= rx_line;
		end
	end

	// LSB arrives first, fill from the top
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_end) begin
			shift_reg <= {rx_line, shift_reg[DATA_BITS-1:1]};
		end
		if (state == RX_STOP && bit_end) begin
			rx_byte <= shift_reg;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= RX_IDLE;
			clk_cnt     <= '0;
			bit_idx     <= '0;
			rx_stb      <= 1'b0;
			rx_stop_err <= 1'b0;
		end else begin
			rx_stb      <= 1'b0;
			rx_stop_err <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (start_edge) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (half_end) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// glitch shorter than half a bit
						state   <= rx_line ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
							state <= RX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						// back to idle at mid stop bit, ready for the next edge
						state       <= RX_IDLE;
						rx_stb      <= rx_line;
						rx_stop_err <= ~rx_line;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_sender.sv ====
// Frame sender
// sends "&&", the payload and "&&" through the byte interface,
// one byte strobe per state after the previous completion

`default_nettype none
`timescale 1ns/1ps

module frame_sender (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    tx_req,
	input  frame_pkg::payload_t     tx_payload,
	input  frame_pkg::payload_len_t tx_length,
	output logic                    tx_busy,
	output logic                    tx_done,
	uart_byte_if.sender             byte_if
);

	import frame_pkg::*;

	localparam int IDX_W = $clog2(MAX_PAYLOAD);

	typedef enum logic [2:0] {
		S_IDLE,
		S_OPEN1,
		S_OPEN2,
		S_DATA,
		S_CLOSE1,
		S_CLOSE2,
		S_FINISH
	} send_state_t;

	send_state_t  state;
	payload_t     payload_q;
	payload_len_t length_q;
	payload_len_t byte_cnt;
	logic         byte_sent;
	logic         req_ok;
	logic         last_byte;

	// lengths outside 1..16 are not accepted
	assign req_ok    = tx_req && (tx_length != '0)
			&& (tx_length <= payload_len_t'(MAX_PAYLOAD));
	assign last_byte = (byte_cnt == length_q - 1'b1);

	assign tx_busy = (state != S_IDLE);
	assign tx_done = (state == S_FINISH);
	assign byte_if.byte_data = (state == S_DATA) ? payload_q[byte_cnt[IDX_W-1:0]] : MARKER_CHAR;

	// inputs may change once the frame has started
	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE && req_ok) begin
			payload_q <= tx_payload;
			length_q  <= tx_length;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state            <= S_IDLE;
			byte_cnt         <= '0;
			byte_sent        <= 1'b0;
			byte_if.byte_stb <= 1'b0;
		end else begin
			byte_if.byte_stb <= 1'b0;
			case (state)
				S_IDLE: begin
					byte_cnt  <= '0;
					byte_sent <= 1'b0;
					if (req_ok) begin
						state <= S_OPEN1;
					end
				end
				S_FINISH: state <= S_IDLE;
				default: begin
					if (!byte_sent && !byte_if.line_busy) begin
						byte_if.byte_stb <= 1'b1;
						byte_sent        <= 1'b1;
					end
					if (byte_if.byte_done) begin
						byte_sent <= 1'b0;
						case (state)
							S_OPEN1:  state <= S_OPEN2;
							S_OPEN2:  state <= S_DATA;
							S_DATA: begin
								if (last_byte) begin
									state <= S_CLOSE1;
								end else begin
									byte_cnt <= byte_cnt + 1'b1;
								end
							end
							S_CLOSE1: state <= S_CLOSE2;
							default:  state <= S_FINISH;
						endcase
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_receiver.sv ====
// Frame receiver
// hunts for "&&", collects payload bytes up to the closing "&&"
// and presents the payload with a done strobe, bad frames are dropped

`default_nettype none
`timescale 1ns/1ps

module frame_receiver (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic [7:0]              rx_byte,
	input  logic                    rx_stb,
	input  logic                    rx_stop_err,
	output frame_pkg::payload_t     rx_payload,
	output frame_pkg::payload_len_t rx_length,
	output logic                    rx_done
);

	import frame_pkg::*;

	localparam int IDX_W = $clog2(MAX_PAYLOAD);

	typedef enum logic [1:0] {
		R_HUNT,
		R_OPEN1,
		R_DATA,
		R_CLOSE1
	} recv_state_t;

	recv_state_t  state;
	payload_t     work_buf;
	payload_len_t byte_cnt;
	logic         is_marker;
	logic         store;
	logic         frame_end;

	assign is_marker = rx_stb && (rx_byte == MARKER_CHAR);
	assign store     = (state == R_DATA) && rx_stb && !is_marker
			&& (byte_cnt < payload_len_t'(MAX_PAYLOAD));
	assign frame_end = (state == R_CLOSE1) && is_marker;

	always_ff @(posedge sys_clk) begin
		if (store) begin
			work_buf[byte_cnt[IDX_W-1:0]] <= rx_byte;
		end
		if (frame_end) begin
			rx_payload <= work_buf;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= R_HUNT;
			byte_cnt  <= '0;
			rx_length <= '0;
			rx_done   <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (rx_stop_err) begin
				state <= R_HUNT;
			end else if (rx_stb) begin
				case (state)
					R_HUNT: begin
						if (is_marker) begin
							state <= R_OPEN1;
						end
					end
					R_OPEN1: begin
						byte_cnt <= '0;
						state    <= is_marker ? R_DATA : R_HUNT;
					end
					R_DATA: begin
						if (is_marker) begin
							// marker on an empty buffer counts as one more opening
							// marker, so "&&&&" never completes
							if (byte_cnt != '0) begin
								state <= R_CLOSE1;
							end
						end else if (byte_cnt == payload_len_t'(MAX_PAYLOAD)) begin
							// seventeenth byte
							state <= R_HUNT;
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
					R_CLOSE1: begin
						// lone '&' inside the payload ends up here too
						state <= R_HUNT;
						if (frame_end) begin
							rx_length <= byte_cnt;
							rx_done   <= 1'b1;
						end
					end
					default: state <= R_HUNT;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_frame_link.sv ====
// Framed string link over one UART line
// sender path and receiver path joined to plain ports

`default_nettype none
`timescale 1ns/1ps

module uart_frame_link (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    tx_req,
	input  frame_pkg::payload_t     tx_payload,
	input  frame_pkg::payload_len_t tx_length,
	output logic                    tx_busy,
	output logic                    tx_done,
	output frame_pkg::payload_t     rx_payload,
	output frame_pkg::payload_len_t rx_length,
	output logic                    rx_done,
	input  logic                    uart_rx_port,
	output logic                    uart_tx_port
);

	uart_byte_if byte_bus ();

	logic [7:0] rx_byte;
	logic       rx_stb;
	logic       rx_stop_err;

	// transmit path
	frame_sender i_frame_sender (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_req     (tx_req),
		.tx_payload (tx_payload),
		.tx_length  (tx_length),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.byte_if    (byte_bus.sender)
	);

	uart_tx i_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.byte_if      (byte_bus.serializer),
		.uart_tx_port (uart_tx_port)
	);

	// receive path
	uart_rx i_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_byte      (rx_byte),
		.rx_stb       (rx_stb),
		.rx_stop_err  (rx_stop_err)
	);

	frame_receiver i_frame_receiver (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_stb      (rx_stb),
		.rx_stop_err (rx_stop_err),
		.rx_payload  (rx_payload),
		.rx_length   (rx_length),
		.rx_done     (rx_done)
	);

endmodule

`default_nettype wire

// ==== tests/uart_frame_properties.sv ====
// Frame link checker
// concurrent assertions on reset state, tx_busy timing and the
// received frame against the testbench's expected record

`default_nettype none
`timescale 1ns/1ps

module uart_frame_properties (
	input logic                    sys_clk,
	input logic                    sys_rst_n,
	input logic                    tx_req,
	input frame_pkg::payload_len_t tx_length,
	input logic                    tx_busy,
	input logic                    tx_done,
	input logic                    rx_done,
	input frame_pkg::payload_len_t rx_length,
	input frame_pkg::payload_t     rx_payload,
	input logic                    uart_tx_port,
	input frame_pkg::payload_len_t exp_length,
	input frame_pkg::payload_t     exp_payload,
	input logic                    rx_pending,
	input logic                    hold_check
);

	import frame_pkg::*;

	int fail_cnt = 0;

	// only the first len bytes carry payload
	function automatic bit payload_match(input payload_t got, input payload_t exp,
			input payload_len_t len);
		for (int i = 0; i < MAX_PAYLOAD; i++) begin
			if (i < int'(len) && got[i] !== exp[i]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	a_reset_state: assert property (@(posedge sys_clk)
			$rose(sys_rst_n) |-> (uart_tx_port && !tx_busy && !tx_done && !rx_done
			&& rx_length == '0))
		else begin
			fail_cnt++;
			$error("outputs are not in their reset state after reset release");
		end

	a_idle_line: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			!tx_busy |-> uart_tx_port)
		else begin
			fail_cnt++;
			$error("[ERROR] %0t uart_tx_port got 0 expected 1 while idle", $time);
		end

	a_busy_rise: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			(tx_req && !tx_busy && tx_length != '0) |=> tx_busy)
		else begin
			fail_cnt++;
			$error("[ERROR] %0t tx_busy got 0 expected 1 after tx_req", $time);
		end

	a_busy_fall: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			tx_done |=> !tx_busy)
		else begin
			fail_cnt++;
			$error("[ERROR] %0t tx_busy got 1 expected 0 after tx_done", $time);
		end

	a_busy_end: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			$fell(tx_busy) |-> $past(tx_done))
		else begin
			fail_cnt++;
			$error("tx_busy fell without a tx_done in the cycle before");
		end

	a_rx_due: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			rx_done |-> rx_pending)
		else begin
			fail_cnt++;
			$error("rx_done pulsed although no good frame was due");
		end

	a_rx_length: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			(rx_done || hold_check) |-> rx_length == exp_length)
		else begin
			fail_cnt++;
			$error("[ERROR] %0t rx_length got %0d expected %0d", $time,
				$sampled(rx_length), $sampled(exp_length));
		end

	a_rx_payload: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			(rx_done || hold_check) |-> payload_match(rx_payload, exp_payload, exp_length))
		else begin
			fail_cnt++;
			$error("[ERROR] %0t rx_payload got %h expected %h", $time,
				$sampled(rx_payload), $sampled(exp_payload));
		end

endmodule

`default_nettype wire

// ==== tests/tb_uart_frame_link.sv ====
// Frame link testbench
// loopback frames with random payloads, then bit-banged bad and
// good frames on the receive line

`default_nettype none
`timescale 1ns/1ps

module tb_uart_frame_link;

	import uart_line_pkg::*;
	import frame_pkg::*;

	localparam int NUM_FRAMES     = 8;
	localparam int CHAR_CYCLES    = 10 * CLKS_PER_BIT;
	// loopback frames at full length plus the bit-banged characters
	localparam int TOTAL_CHARS    = NUM_FRAMES * (MAX_PAYLOAD + 4) + 50;
	localparam int TIMEOUT_CYCLES = TOTAL_CHARS * CHAR_CYCLES * 3 / 2 + 2000;

	logic         sys_clk;
	logic         sys_rst_n;
	logic         tx_req;
	payload_t     tx_payload;
	payload_len_t tx_length;
	logic         tx_busy;
	logic         tx_done;
	payload_t     rx_payload;
	payload_len_t rx_length;
	logic         rx_done;
	logic         uart_rx_port;
	logic         uart_tx_port;

	logic         line_sel;
	logic         bb_line;
	payload_t     exp_payload;
	payload_len_t exp_length;
	logic         hold_check;
	logic         rx_pending;
	logic [15:0]  lfsr_state;
	int           exp_done_cnt = 0;
	int           rx_done_cnt  = 0;
	int           tx_done_cnt  = 0;
	int           accepted_cnt = 0;
	int           err_cnt      = 0;
	int           cycle_cnt    = 0;

	// loopback or bit-banged receive line
	assign uart_rx_port = line_sel ? uart_tx_port : bb_line;
	assign rx_pending   = (rx_done_cnt < exp_done_cnt);

	uart_frame_link i_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_req       (tx_req),
		.tx_payload   (tx_payload),
		.tx_length    (tx_length),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_payload   (rx_payload),
		.rx_length    (rx_length),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	bind uart_frame_link uart_frame_properties i_props (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_req       (tx_req),
		.tx_length    (tx_length),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_done      (rx_done),
		.rx_length    (rx_length),
		.rx_payload   (rx_payload),
		.uart_tx_port (uart_tx_port),
		.exp_length   (tb_uart_frame_link.exp_length),
		.exp_payload  (tb_uart_frame_link.exp_payload),
		.rx_pending   (tb_uart_frame_link.rx_pending),
		.hold_check   (tb_uart_frame_link.hold_check)
	);

	initial sys_clk = 1'b0;
	always #5 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (rx_done) begin
			rx_done_cnt <= rx_done_cnt + 1;
		end
		if (tx_done) begin
			tx_done_cnt <= tx_done_cnt + 1;
		end
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	task automatic make_payload(output payload_t p, output payload_len_t len);
		logic [7:0] v;
		rand_bits(4, v);
		len = {1'b0, v[3:0]} + 5'd1;
		p = '0;
		for (int i = 0; i < int'(len); i++) begin
			rand_bits(8, v);
			// markers are not allowed inside a payload
			if (v == MARKER_CHAR) begin
				v = v + 8'd1;
			end
			p[i] = v;
		end
	endtask

	task automatic send_bit(input logic b);
		bb_line <= b;
		repeat (CLKS_PER_BIT) @(posedge sys_clk);
	endtask

	task automatic send_char(input logic [7:0] c, input logic stop_bit);
		send_bit(1'b0);
		for (int i = 0; i < DATA_BITS; i++) begin
			send_bit(c[i]);
		end
		send_bit(stop_bit);
		// a low stop bit needs an idle bit before the next start edge
		if (!stop_bit) begin
			send_bit(1'b1);
		end
	endtask

	task automatic send_marks();
		send_char(MARKER_CHAR, 1'b1);
		send_char(MARKER_CHAR, 1'b1);
	endtask

	task automatic wait_rx_done();
		while (rx_done_cnt < exp_done_cnt) begin
			@(posedge sys_clk);
		end
	endtask

	task automatic send_loopback(input logic busy_req);
		payload_t     p;
		payload_len_t len;
		make_payload(p, len);
		tx_payload   <= p;
		tx_length    <= len;
		tx_req       <= 1'b1;
		exp_payload  <= p;
		exp_length   <= len;
		exp_done_cnt <= exp_done_cnt + 1;
		accepted_cnt <= accepted_cnt + 1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		if (busy_req) begin
			// ignored while the sender is busy
			repeat (20) @(posedge sys_clk);
			tx_length <= 5'd3;
			tx_req    <= 1'b1;
			@(posedge sys_clk);
			tx_req <= 1'b0;
		end
		while (!tx_done) begin
			@(posedge sys_clk);
		end
		wait_rx_done();
		repeat (4) @(posedge sys_clk);
	endtask

	initial begin
		payload_t p;
		int       total;
		lfsr_state  = 16'd70;
		sys_rst_n   = 1'b0;
		tx_req      = 1'b0;
		tx_payload  = '0;
		tx_length   = '0;
		line_sel    = 1'b1;
		bb_line     = 1'b1;
		exp_payload = '0;
		exp_length  = '0;
		hold_check  = 1'b0;
		repeat (8) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		repeat (5) @(posedge sys_clk);

		for (int f = 0; f < NUM_FRAMES; f++) begin
			send_loopback(f == 2);
		end

		// bad frames leave the last loopback frame on the outputs
		line_sel   <= 1'b0;
		hold_check <= 1'b1;
		repeat (2 * CLKS_PER_BIT) @(posedge sys_clk);
		send_marks();
		send_char(8'h61, 1'b1);
		send_char(MARKER_CHAR, 1'b1);
		send_char(8'h62, 1'b1);
		send_marks();
		send_marks();
		send_marks();
		send_marks();
		send_marks();
		send_char(8'h63, 1'b1);
		send_char(8'h64, 1'b0);
		send_marks();
		repeat (4 * CLKS_PER_BIT) @(posedge sys_clk);

		// good bit-banged frame
		p = '0;
		for (int i = 0; i < 6; i++) begin
			p[i] = 8'h41 + 8'(i);
		end
		hold_check   <= 1'b0;
		exp_payload  <= p;
		exp_length   <= 5'd6;
		exp_done_cnt <= exp_done_cnt + 1;
		send_marks();
		for (int i = 0; i < 6; i++) begin
			send_char(p[i], 1'b1);
		end
		send_marks();
		wait_rx_done();

		// seventeen bytes
		hold_check <= 1'b1;
		send_marks();
		for (int i = 0; i < MAX_PAYLOAD + 1; i++) begin
			send_char(8'h30 + 8'(i), 1'b1);
		end
		send_marks();
		repeat (4 * CLKS_PER_BIT) @(posedge sys_clk);
		hold_check <= 1'b0;
		@(posedge sys_clk);

		if (tx_done_cnt != accepted_cnt) begin
			$display("[ERROR] %0t tx_done_cnt got %0d expected %0d", $time,
				tx_done_cnt, accepted_cnt);
			err_cnt++;
		end
		if (rx_done_cnt != exp_done_cnt) begin
			$display("[ERROR] %0t rx_done_cnt got %0d expected %0d", $time,
				rx_done_cnt, exp_done_cnt);
			err_cnt++;
		end
		total = err_cnt + i_dut.i_props.fail_cnt;
		$display("errors: %0d testbench checks, %0d assertion failures",
			err_cnt, i_dut.i_props.fail_cnt);
		if (total == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/uart_line_pkg.sv
hw/frame_pkg.sv
hw/uart_byte_if.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/frame_sender.sv
hw/frame_receiver.sv
hw/uart_frame_link.sv
tests/uart_frame_properties.sv
tests/tb_uart_frame_link.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_uart_frame_link -o sim_tb \
	|| exit 1
out="$(./obj_dir/sim_tb +verilator+error+limit+1000)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'All tests passed' && exit 0 || exit 1
